// ==== Makefile ====
TOP = ifu_front_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f ifu_front.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f ifu_front.f --top-module $(TOP) -o sim_top
	./obj_dir/sim_top | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/ifu_front.sv ====
`timescale 1ns/1ps

module ifu_front (
    input  logic                     clk,
    input  logic                     reset,
    // redirects
    input  logic                     br_taken,
    input  logic [31:0]              br_target,
    input  logic                     flush,
    input  logic                     flush_refill,
    input  logic                     eret,
    input  logic [31:0]              epc,
    input  logic                     refetch,
    input  logic [31:0]              refetch_pc,
    // main tlb lookup
    input  logic                     tlb_buffer_flush,
    output logic [31:13]             tlb_vpn,
    input  logic                     tlb_found,
    input  tlb_entry_pkg::tlb_half_t tlb_even,
    input  tlb_entry_pkg::tlb_half_t tlb_odd,
    // instruction memory
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [31:0]              wb_adr,
    input  logic [31:0]              wb_dat_i,
    input  logic                     wb_ack,
    // decode side
    input  logic                     ds_allowin,
    output logic                     fetch_valid,
    output logic [31:0]              fetch_pc,
    output logic [31:0]              fetch_inst,
    output logic                     fetch_ex,
    output logic                     fetch_bdd,
    output mips_exc_pkg::exc_code_t  fetch_exc
);
    import mips_exc_pkg::*;

    logic [31:0] ps_pc;
    logic [31:0] ps_pa;
    logic        ps_valid;
    logic        ps_ex;
    logic        ps_bdd;
    exc_code_t   ps_exc;
    logic        fs_allowin;
    logic        itlb_stall;
    logic        itlb_ex;
    exc_code_t   itlb_exc;
    logic        fs_flush;

    // eret also kills everything younger than itself
    assign fs_flush = flush | eret;

    pre_if_stage pre_if_stage_inst (
        .clk          (clk),
        .reset        (reset),
        .br_taken     (br_taken),
        .br_target    (br_target),
        .flush        (flush),
        .flush_refill (flush_refill),
        .eret         (eret),
        .epc          (epc),
        .refetch      (refetch),
        .refetch_pc   (refetch_pc),
        .fs_allowin   (fs_allowin),
        .itlb_stall   (itlb_stall),
        .itlb_ex      (itlb_ex),
        .itlb_exc     (itlb_exc),
        .ps_pc        (ps_pc),
        .ps_valid     (ps_valid),
        .ps_ex        (ps_ex),
        .ps_bdd       (ps_bdd),
        .ps_exc       (ps_exc)
    );

    itlb_stage itlb_stage_inst (
        .clk              (clk),
        .reset            (reset),
        .vaddr            (ps_pc),
        .tlb_buffer_flush (tlb_buffer_flush),
        .tlb_found        (tlb_found),
        .tlb_even         (tlb_even),
        .tlb_odd          (tlb_odd),
        .tlb_vpn          (tlb_vpn),
        .paddr            (ps_pa),
        .itlb_stall       (itlb_stall),
        .itlb_ex          (itlb_ex),
        .itlb_exc         (itlb_exc)
    );

    inst_fetch_wb inst_fetch_wb_inst (
        .clk         (clk),
        .reset       (reset),
        .ps_valid    (ps_valid),
        .ps_pc       (ps_pc),
        .ps_pa       (ps_pa),
        .ps_ex       (ps_ex),
        .ps_bdd      (ps_bdd),
        .ps_exc      (ps_exc),
        .flush       (fs_flush),
        .fs_allowin  (fs_allowin),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .ds_allowin  (ds_allowin),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .fetch_ex    (fetch_ex),
        .fetch_bdd   (fetch_bdd),
        .fetch_exc   (fetch_exc)
    );

endmodule

// ==== hw/inst_fetch_wb.sv ====
`timescale 1ns/1ps

module inst_fetch_wb (
    input  logic                    clk,
    input  logic                    reset,
    // item from pre-fetch
    input  logic                    ps_valid,
    input  logic [31:0]             ps_pc,
    input  logic [31:0]             ps_pa,
    input  logic                    ps_ex,
    input  logic                    ps_bdd,
    input  mips_exc_pkg::exc_code_t ps_exc,
    input  logic                    flush,     // flush or eret
    output logic                    fs_allowin,
    // wishbone classic read master
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [31:0]             wb_adr,
    input  logic [31:0]             wb_dat_i,
    input  logic                    wb_ack,
    // toward decode
    input  logic                    ds_allowin,
    output logic                    fetch_valid,
    output logic [31:0]             fetch_pc,
    output logic [31:0]             fetch_inst,
    output logic                    fetch_ex,
    output logic                    fetch_bdd,
    output mips_exc_pkg::exc_code_t fetch_exc
);
    import mips_exc_pkg::*;

    logic        cyc_q;
    logic        discard_q;  // open cycle belongs to a flushed item
    logic [31:0] adr_q;
    logic [31:0] pend_pc;
    logic        pend_bdd;
    logic        accept;
    logic        bus_done;
    exc_code_t   out_exc;

    assign fs_allowin = ~cyc_q & (~fetch_valid | ds_allowin);
    assign accept     = ps_valid & fs_allowin & ~flush;
    assign bus_done   = cyc_q & wb_ack & ~discard_q & ~flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            cyc_q     <= 1'b0;
            discard_q <= 1'b0;
        end else begin
            if (accept & ~ps_ex) begin
                cyc_q <= 1'b1;
            end else if (cyc_q & wb_ack) begin
                cyc_q <= 1'b0;
            end
            if (cyc_q & wb_ack) begin
                discard_q <= 1'b0;
            end else if (cyc_q & flush) begin
                discard_q <= 1'b1;  // let the slave finish, ignore the data
            end
        end
    end

    // address and item info held for the whole cycle
    always_ff @(posedge clk) begin
        if (accept & ~ps_ex) begin
            adr_q    <= ps_pa;
            pend_pc  <= ps_pc;
            pend_bdd <= ps_bdd;
        end
    end

    assign wb_cyc = cyc_q;
    assign wb_stb = cyc_q;
    assign wb_we  = 1'b0;
    assign wb_adr = adr_q;

    // output slot
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
        end else if (flush) begin
            fetch_valid <= 1'b0;
        end else if (bus_done | (accept & ps_ex)) begin
            fetch_valid <= 1'b1;
        end else if (ds_allowin) begin
            fetch_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_done) begin
            fetch_pc   <= pend_pc;
            fetch_inst <= wb_dat_i;
            fetch_ex   <= 1'b0;
            out_exc    <= exc_none;
            fetch_bdd  <= pend_bdd;
        end else if (accept & ps_ex) begin
            // faulting item never touches the bus
            fetch_pc   <= ps_pc;
            fetch_inst <= 32'd0;
            fetch_ex   <= 1'b1;
            out_exc    <= ps_exc;
            fetch_bdd  <= ps_bdd;
        end
    end

    assign fetch_exc = out_exc;

endmodule

// ==== hw/itlb_stage.sv ====
`timescale 1ns/1ps
`include "ifu_params.svh"

module itlb_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              vaddr,
    input  logic                     tlb_buffer_flush,
    // answer from the main tlb, same cycle as tlb_vpn
    input  logic                     tlb_found,
    input  tlb_entry_pkg::tlb_half_t tlb_even,
    input  tlb_entry_pkg::tlb_half_t tlb_odd,
    output logic [31:13]             tlb_vpn,
    output logic [31:0]              paddr,
    output logic                     itlb_stall,
    output logic                     itlb_ex,
    output mips_exc_pkg::exc_code_t  itlb_exc
);
    import mips_exc_pkg::*;
    import tlb_entry_pkg::*;

    logic [`VPN_WD-1:0] vpn;
    logic               unmapped;
    logic               hit;
    tlb_half_t          sel_half;

    // captured page pair
    logic               ent_valid;
    logic [31:13]       ent_vpn2;
    logic               ent_found;  // cleared when the main tlb had no match
    tlb_half_t          ent_even;
    tlb_half_t          ent_odd;

    assign vpn = vaddr[31:32-`VPN_WD];

    // kseg0 and kseg1 bypass the tlb
    assign unmapped = vaddr[31:30] == 2'b10;

    assign hit      = ent_valid & (ent_vpn2 == vpn[`VPN_WD-1:1]);
    assign sel_half = vpn[0] ? ent_odd : ent_even;

    assign tlb_vpn    = vpn[`VPN_WD-1:1];
    assign itlb_stall = ~unmapped & ~hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            ent_valid <= 1'b0;
        end else if (tlb_buffer_flush) begin
            ent_valid <= 1'b0;   // main tlb was written, drop the copy
        end else if (itlb_stall) begin
            ent_valid <= 1'b1;
        end
    end

    // payload, only looked at while ent_valid is set
    always_ff @(posedge clk) begin
        if (itlb_stall) begin
            ent_vpn2  <= vpn[`VPN_WD-1:1];
            ent_found <= tlb_found;
            ent_even  <= tlb_even;
            ent_odd   <= tlb_odd;
        end
    end

    always_comb begin
        if (unmapped) begin
            paddr = {3'b000, vaddr[28:0]};
        end else begin
            paddr = {sel_half.pfn, vaddr[11:0]};
        end
    end

    // only a resolved mapped lookup can fault
    assign itlb_ex  = ~unmapped & hit & (~ent_found | ~sel_half.v);
    assign itlb_exc = ~itlb_ex   ? exc_none        :
                      ~ent_found ? exc_tlbl_refill :
                                   exc_tlbl_inv;

endmodule

// ==== hw/mips_exc_pkg.sv ====
package mips_exc_pkg;

    // exception tag carried with each fetched item
    // bits 3:0 hold the CP0 ExcCode, bit 4 is the refill flag
    // tlbl_refill and tlbl_inv both report ExcCode 2 to CP0,
    // the flag picks the refill vector over the general one
    typedef enum logic [4:0] {
        exc_none        = 5'h00,
        exc_tlbl_inv    = 5'h02,
        exc_adel        = 5'h04,
        exc_tlbl_refill = 5'h12
    } exc_code_t;

    // source of the next fetch PC, listed from lowest priority up
    typedef enum logic [2:0] {
        pc_sel_seq,     // pc + 4
        pc_sel_branch,  // taken branch from decode
        pc_sel_general, // general exception vector
        pc_sel_refetch, // replay of a refetched instruction
        pc_sel_refill,  // tlb refill vector
        pc_sel_eret     // return to epc
    } pc_sel_t;

endpackage

// ==== hw/pre_if_stage.sv ====
`timescale 1ns/1ps
`include "ifu_params.svh"

module pre_if_stage (
    input  logic                    clk,
    input  logic                    reset,
    // redirects from later stages
    input  logic                    br_taken,
    input  logic [31:0]             br_target,
    input  logic                    flush,
    input  logic                    flush_refill,
    input  logic                    eret,
    input  logic [31:0]             epc,
    input  logic                    refetch,
    input  logic [31:0]             refetch_pc,
    // back-pressure from fetch
    input  logic                    fs_allowin,
    // translation status for the current pc
    input  logic                    itlb_stall,
    input  logic                    itlb_ex,
    input  mips_exc_pkg::exc_code_t itlb_exc,
    // item toward fetch
    output logic [31:0]             ps_pc,
    output logic                    ps_valid,
    output logic                    ps_ex,
    output logic                    ps_bdd,
    output mips_exc_pkg::exc_code_t ps_exc
);
    import mips_exc_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] seq_pc;
    logic [31:0] next_pc;
    pc_sel_t     pc_sel;
    logic        adel_ex;
    logic        pc_load;

    assign seq_pc = pc_q + 32'd4;

    // eret beats flush, flush beats branch
    always_comb begin
        if (eret) begin
            pc_sel = pc_sel_eret;
        end else if (flush) begin
            if (flush_refill) begin
                pc_sel = pc_sel_refill;
            end else if (refetch) begin
                pc_sel = pc_sel_refetch;
            end else begin
                pc_sel = pc_sel_general;
            end
        end else if (br_taken) begin
            pc_sel = pc_sel_branch;
        end else begin
            pc_sel = pc_sel_seq;
        end
    end

    always_comb begin
        case (pc_sel)
            pc_sel_eret:    next_pc = epc;
            pc_sel_refill:  next_pc = `REFILL_EX_PC;
            pc_sel_refetch: next_pc = refetch_pc;
            pc_sel_general: next_pc = `GENERAL_EX_PC;
            pc_sel_branch:  next_pc = br_target;
            default:        next_pc = seq_pc;
        endcase
    end

    // advance on a transfer, redirects load unconditionally
    assign pc_load = (ps_valid & fs_allowin) | flush | eret;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= `RESET_PC;
        end else if (pc_load) begin
            pc_q <= next_pc;
        end
    end

    assign ps_pc = pc_q;

    // fetch is word sized
    assign adel_ex = pc_q[1:0] != 2'b00;

    // a misaligned pc needs no translation, so it may leave during a stall
    assign ps_valid = adel_ex | ~itlb_stall;

    // adel wins over any tlb fault on the same pc
    assign ps_ex  = adel_ex | itlb_ex;
    assign ps_exc = adel_ex ? exc_adel :
                    itlb_ex ? itlb_exc :
                              exc_none;

    // this item is the one after the delay slot, its successor is the target
    assign ps_bdd = br_taken & ~flush & ~eret;

endmodule

// ==== hw/tlb_entry_pkg.sv ====
`include "ifu_params.svh"

package tlb_entry_pkg;

    // C field of EntryLo, 2 = uncached, 3 = cacheable
    typedef logic [2:0] cache_attr_t;

    // one half of an even/odd page pair
    typedef struct packed {
        logic [`PFN_WD-1:0] pfn;
        cache_attr_t        c;
        logic               d;  // dirty, i.e. writable
        logic               v;  // valid
    } tlb_half_t;

endpackage

// ==== ifu_front.f ====
+incdir+include
hw/mips_exc_pkg.sv
hw/tlb_entry_pkg.sv
hw/pre_if_stage.sv
hw/itlb_stage.sv
hw/inst_fetch_wb.sv
hw/ifu_front.sv
tb/ifu_clk_gen.sv
tb/ifu_front_chk.sv
tb/ifu_front_mon.sv
tb/ifu_front_tb.sv

// ==== include/ifu_params.svh ====
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// boot rom entry in kseg1
`define RESET_PC      32'hbfc0_0000

// exception entry points while BEV is set
`define GENERAL_EX_PC 32'hbfc0_0380
`define REFILL_EX_PC  32'hbfc0_0200

// virtual page number, 4 KB pages
`define VPN_WD 20

// physical frame number, kept 32-bit physical space
`define PFN_WD 20

`endif

// ==== tb/ifu_clk_gen.sv ====
`timescale 1ns/1ps

module ifu_clk_gen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end
endmodule

// ==== tb/ifu_front_chk.sv ====
`timescale 1ns/1ps

module ifu_front_chk (
    input logic        clk,
    input logic        reset,
    input logic        flush,
    input logic        eret,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_ack,
    input logic [31:0] wb_adr,
    input logic        ds_allowin,
    input logic        fetch_valid,
    input logic [31:0] fetch_pc,
    input logic [31:0] fetch_inst,
    input logic [4:0]  fetch_exc
);
    int fail_cnt = 0;

    cyc_stb_a: assert property (@(posedge clk) disable iff (reset) wb_cyc == wb_stb)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("wishbone cyc and stb differ");
        end

    // address held until the slave acks
    adr_hold_a: assert property (@(posedge clk) disable iff (reset)
        (wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr)))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("wishbone address changed before ack");
        end

    out_hold_a: assert property (@(posedge clk) disable iff (reset)
        (fetch_valid && !ds_allowin && !flush && !eret) |=>
        (fetch_valid && $stable(fetch_pc) && $stable(fetch_inst) && $stable(fetch_exc)))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("fetch output changed under back-pressure");
        end
endmodule

bind ifu_front ifu_front_chk ifu_front_chk_inst (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .eret        (eret),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .wb_adr      (wb_adr),
    .ds_allowin  (ds_allowin),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_inst  (fetch_inst),
    .fetch_exc   (fetch_exc)
);

// ==== tb/ifu_front_mon.sv ====
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_front_mon (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    br_taken,
    input  logic [31:0]             br_target,
    input  logic                    flush,
    input  logic                    flush_refill,
    input  logic                    eret,
    input  logic [31:0]             epc,
    input  logic                    refetch,
    input  logic [31:0]             refetch_pc,
    input  logic                    xfer,
    input  logic [31:0]             xfer_pc,
    input  logic                    wb_we,
    input  logic                    ds_allowin,
    input  logic                    fetch_valid,
    input  logic [31:0]             fetch_pc,
    input  logic [31:0]             fetch_inst,
    input  logic                    fetch_ex,
    input  logic                    fetch_bdd,
    input  mips_exc_pkg::exc_code_t fetch_exc,
    input  logic                    row_start,
    input  logic                    row_armed,
    input  logic [31:0]             row_pc,
    input  mips_exc_pkg::exc_code_t row_exc,
    output int                      err_pc,
    output int                      err_inst,
    output int                      err_exc,
    output int                      err_bdd,
    output int                      err_other
);
    import mips_exc_pkg::*;

    logic [31:0] exp_pc;
    logic        bdd_pending;
    logic [31:0] bdd_pc;
    logic [31:0] bdd_target;
    logic        armed;
    logic [31:0] chk_pc;
    exc_code_t   chk_exc;
    exc_code_t   p_exc;
    logic [31:0] p_inst;
    logic        p_bdd;

    // reference translation, page table of the tb tlb model
    function automatic void predict(input logic [31:0] pc, output exc_code_t exc,
                                    output logic [31:0] inst);
        logic [31:0] pa;
        pa = 32'd0;
        exc = exc_none;
        if (pc[1:0] != 2'b00) begin
            exc = exc_adel;
        end else if (pc[31:30] == 2'b10) begin
            pa = {3'b000, pc[28:0]};
        end else if (pc[31:13] == 19'h00200) begin
            pa = {(pc[12] ? 20'h01235 : 20'h01234), pc[11:0]};
        end else if (pc[31:13] == 19'h00300) begin
            if (pc[12]) begin
                exc = exc_tlbl_inv;  // odd half not valid
            end else begin
                pa = {20'h02000, pc[11:0]};
            end
        end else begin
            exc = exc_tlbl_refill;
        end
        inst = (exc == exc_none) ? (pa ^ 32'h5a5a0000) : 32'd0;
    endfunction

    initial begin
        err_pc = 0;
        err_inst = 0;
        err_exc = 0;
        err_bdd = 0;
        err_other = 0;
        armed = 1'b0;
    end

    always @(posedge clk) begin
        if (reset) begin
            exp_pc = `RESET_PC;
            bdd_pending = 1'b0;
            armed = 1'b0;
        end else begin
            // instruction fetch never writes
            if (wb_we !== 1'b0) begin
                $display("ERR %0t wb_we exp 0 got %b", $time, wb_we);
                err_other++;
            end
            if (row_start) begin
                if (armed) begin
                    $display("redirect target %h was never fetched", chk_pc);
                    err_other++;
                end
                armed = row_armed;
                chk_pc = row_pc;
                chk_exc = row_exc;
            end
            if (fetch_valid && ds_allowin && !flush && !eret) begin
                predict(fetch_pc, p_exc, p_inst);
                p_bdd = bdd_pending && (fetch_pc == bdd_pc);
                if (fetch_pc !== exp_pc) begin
                    $display("ERR %0t fetch_pc exp %h got %h", $time, exp_pc, fetch_pc);
                    err_pc++;
                end
                if (fetch_inst !== p_inst) begin
                    $display("ERR %0t fetch_inst exp %h got %h", $time, p_inst, fetch_inst);
                    err_inst++;
                end
                if (fetch_exc !== p_exc || fetch_ex !== (p_exc != exc_none)) begin
                    $display("ERR %0t fetch_exc exp %h got %h", $time, p_exc, fetch_exc);
                    err_exc++;
                end
                if (fetch_bdd !== p_bdd) begin
                    $display("ERR %0t fetch_bdd exp %b got %b", $time, p_bdd, fetch_bdd);
                    err_bdd++;
                end
                if (armed && fetch_pc == chk_pc) begin
                    if (fetch_exc !== chk_exc) begin
                        $display("ERR %0t fetch_exc exp %h got %h", $time, chk_exc, fetch_exc);
                        err_exc++;
                    end
                    armed = 1'b0;
                end
                exp_pc = p_bdd ? bdd_target : fetch_pc + 32'd4;  // resync on mismatch
                if (p_bdd) begin
                    bdd_pending = 1'b0;
                end
            end
            if (br_taken && xfer && !flush && !eret) begin
                bdd_pending = 1'b1;
                bdd_pc = xfer_pc;
                bdd_target = br_target;
            end
            if (flush || eret) begin
                exp_pc = eret ? epc : flush_refill ? `REFILL_EX_PC :
                         refetch ? refetch_pc : `GENERAL_EX_PC;
                bdd_pending = 1'b0;
            end
        end
    end
endmodule

// ==== tb/ifu_front_tb.sv ====
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_front_tb;
    import mips_exc_pkg::*;
    import tlb_entry_pkg::*;

    localparam int n_rows = 15;
    localparam logic [3:0] kind_none = 4'd0;
    localparam logic [3:0] kind_branch = 4'd1;
    localparam logic [3:0] kind_eret = 4'd2;
    localparam logic [3:0] kind_flush_gen = 4'd3;
    localparam logic [3:0] kind_flush_refetch = 4'd4;
    localparam logic [3:0] kind_flush_refill = 4'd5;
    localparam logic [3:0] kind_eret_flush = 4'd6;
    localparam logic [3:0] kind_tlb_flush = 4'd7;

    typedef struct packed {
        logic [3:0]  kind;
        logic [31:0] value;     // branch target, epc or refetch_pc
        logic [31:0] first_pc;  // zero means nothing to check
        logic [7:0]  count;
        logic [1:0]  stall;     // 0 none, 1 random, 2 long holds
        exc_code_t   exc;
    } row_t;

    logic clk, reset;
    logic br_taken, flush, flush_refill, eret, refetch, tlb_buffer_flush;
    logic [31:0] br_target, epc, refetch_pc;
    logic [31:13] tlb_vpn;
    logic tlb_found;
    tlb_half_t tlb_even, tlb_odd;
    logic wb_cyc, wb_stb, wb_we;
    logic wb_ack = 1'b0;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_i = 32'd0;
    logic fetch_valid, fetch_ex, fetch_bdd;
    logic ds_allowin = 1'b0;
    logic [31:0] fetch_pc, fetch_inst;
    exc_code_t fetch_exc;

    logic [15:0] lfsr = 16'd19;
    logic [1:0] stall_mode;
    logic hold_ds;
    logic [2:0] hold_cnt;
    logic [1:0] mem_wait;
    logic mem_busy;
    row_t rows [n_rows];
    logic row_start, row_armed;
    logic [31:0] row_pc;
    exc_code_t row_exc;
    int err_pc, err_inst, err_exc, err_bdd, err_other;

    ifu_clk_gen ifu_clk_gen_inst (.clk(clk), .reset(reset));

    ifu_front ifu_front_inst (.*);

    ifu_front_mon ifu_front_mon_inst (
        .xfer    (ifu_front_inst.ps_valid & ifu_front_inst.fs_allowin),
        .xfer_pc (ifu_front_inst.ps_pc),
        .*
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // main tlb: two page pairs, everything else misses
    always_comb begin
        tlb_found = 1'b0;
        tlb_even = '0;
        tlb_odd = '0;
        if (tlb_vpn == 19'h00200) begin
            tlb_found = 1'b1;
            tlb_even = {20'h01234, 3'd3, 1'b0, 1'b1};
            tlb_odd = {20'h01235, 3'd3, 1'b0, 1'b1};
        end else if (tlb_vpn == 19'h00300) begin
            tlb_found = 1'b1;
            tlb_even = {20'h02000, 3'd2, 1'b0, 1'b1};
            tlb_odd = {20'h02001, 3'd2, 1'b0, 1'b0};  // invalid
        end
    end

    // memory slave and ds_allowin, sharing the lfsr
    always @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            mem_busy <= 1'b0;
            ds_allowin <= 1'b0;
            hold_cnt <= 3'd0;
        end else begin
            wb_ack <= 1'b0;
            if (mem_busy) begin
                if (mem_wait == 2'd0) begin
                    wb_ack <= 1'b1;
                    wb_dat_i <= wb_adr ^ 32'h5a5a0000;
                    mem_busy <= 1'b0;
                end else begin
                    mem_wait <= mem_wait - 2'd1;
                end
            end else if (wb_cyc && !wb_ack) begin
                // two fresh bits give a wait of 0 to 3 cycles
                lfsr = lfsr_next(lfsr);
                lfsr = lfsr_next(lfsr);
                if ({lfsr[1], lfsr[0]} == 2'd0) begin
                    wb_ack <= 1'b1;  // zero wait
                    wb_dat_i <= wb_adr ^ 32'h5a5a0000;
                end else begin
                    mem_busy <= 1'b1;
                    mem_wait <= {lfsr[1], lfsr[0]} - 2'd1;
                end
            end
            hold_cnt <= hold_cnt + 3'd1;
            case (stall_mode)
                2'd1: begin
                    lfsr = lfsr_next(lfsr);
                    ds_allowin <= lfsr[0] & ~hold_ds;
                end
                2'd2: ds_allowin <= (hold_cnt == 3'd7) & ~hold_ds;  // long holds
                default: ds_allowin <= ~hold_ds;
            endcase
        end
    end

    task automatic apply_redirect(input row_t row);
        case (row.kind)
            kind_none: begin
            end
            kind_branch: begin
                br_target <= row.value;
                br_taken <= 1'b1;
                do begin
                    @(posedge clk);
                end while (!(ifu_front_inst.ps_valid && ifu_front_inst.fs_allowin));
                br_taken <= 1'b0;
            end
            kind_tlb_flush: begin
                tlb_buffer_flush <= 1'b1;
                @(posedge clk);
                tlb_buffer_flush <= 1'b0;
            end
            default: begin
                hold_ds <= 1'b1;  // decode takes nothing in the flush cycle
                @(posedge clk);
                eret <= row.kind == kind_eret || row.kind == kind_eret_flush;
                flush <= row.kind != kind_eret;
                flush_refill <= row.kind == kind_flush_refill || row.kind == kind_eret_flush;
                refetch <= row.kind == kind_flush_refetch || row.kind == kind_flush_refill;
                epc <= row.value;
                refetch_pc <= row.value;
                @(posedge clk);
                eret <= 1'b0;
                flush <= 1'b0;
                flush_refill <= 1'b0;
                refetch <= 1'b0;
                hold_ds <= 1'b0;
            end
        endcase
    endtask

    initial begin
        int n;
        int total;
        br_taken = 1'b0;
        br_target = 32'd0;
        flush = 1'b0;
        flush_refill = 1'b0;
        eret = 1'b0;
        epc = 32'd0;
        refetch = 1'b0;
        refetch_pc = 32'd0;
        tlb_buffer_flush = 1'b0;
        stall_mode = 2'd0;
        hold_ds = 1'b0;
        row_start = 1'b0;
        row_armed = 1'b0;
        row_pc = 32'd0;
        row_exc = exc_none;
        rows[0] = {kind_none, 32'd0, `RESET_PC, 8'd6, 2'd0, exc_none};
        rows[1] = {kind_none, 32'd0, 32'd0, 8'd10, 2'd1, exc_none};
        rows[2] = {kind_branch, 32'hbfc01000, 32'hbfc01000, 8'd6, 2'd0, exc_none};
        rows[3] = {kind_eret, 32'hbfc02000, 32'hbfc02000, 8'd6, 2'd1, exc_none};
        rows[4] = {kind_flush_gen, 32'd0, `GENERAL_EX_PC, 8'd5, 2'd2, exc_none};
        rows[5] = {kind_flush_refetch, 32'hbfc03000, 32'hbfc03000, 8'd5, 2'd1, exc_none};
        rows[6] = {kind_flush_refill, 32'hbfc03000, `REFILL_EX_PC, 8'd5, 2'd0, exc_none};
        rows[7] = {kind_eret_flush, 32'hbfc04000, 32'hbfc04000, 8'd4, 2'd1, exc_none};
        rows[8] = {kind_branch, 32'h00400ff0, 32'h00400ff0, 8'd10, 2'd1, exc_none};
        rows[9] = {kind_tlb_flush, 32'd0, 32'd0, 8'd4, 2'd0, exc_none};
        rows[10] = {kind_branch, 32'h00601000, 32'h00601000, 8'd3, 2'd0, exc_tlbl_inv};
        rows[11] = {kind_branch, 32'h00800000, 32'h00800000, 8'd3, 2'd1, exc_tlbl_refill};
        rows[12] = {kind_branch, 32'hbfc00102, 32'hbfc00102, 8'd3, 2'd0, exc_adel};
        rows[13] = {kind_flush_gen, 32'd0, `GENERAL_EX_PC, 8'd4, 2'd1, exc_none};
        rows[14] = {kind_branch, 32'h00600000, 32'h00600000, 8'd4, 2'd2, exc_none};
        wait (reset == 1'b0);
        @(posedge clk);
        for (int r = 0; r < n_rows; r++) begin
            row_pc <= rows[r].first_pc;
            row_exc <= rows[r].exc;
            row_armed <= rows[r].first_pc != 32'd0;
            row_start <= 1'b1;
            stall_mode <= rows[r].stall;
            @(posedge clk);
            row_start <= 1'b0;
            apply_redirect(rows[r]);
            n = 0;
            while (n < rows[r].count) begin
                @(posedge clk);
                if (fetch_valid && ds_allowin && !flush && !eret) begin
                    n++;
                end
            end
        end
        row_armed <= 1'b0;
        row_start <= 1'b1;  // closes the last row
        @(posedge clk);
        row_start <= 1'b0;
        repeat (2) @(posedge clk);
        total = err_pc + err_inst + err_exc + err_bdd + err_other +
                ifu_front_inst.ifu_front_chk_inst.fail_cnt;
        $display("errors: pc %0d inst %0d exc %0d bdd %0d other %0d assert %0d",
                 err_pc, err_inst, err_exc, err_bdd, err_other,
                 ifu_front_inst.ifu_front_chk_inst.fail_cnt);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (n_rows * 200) @(posedge clk);
        $display("timeout, the test table did not finish in time");
        $display("sim failed");
        $finish;
    end
endmodule
